// ==== isog_pkg.sv ====
package isog_pkg;

  // one radix word and the operand depth per GF(p^2) half
  localparam int WORD_BITS = 32;
  localparam int MEM_DEPTH = 14;
  localparam int ADDR_BITS = 4;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  // engine function code
  typedef logic [7:0] func_t;

  localparam func_t FUNC_IDLE        = 8'd0;
  localparam func_t FUNC_GET_4_ISOG  = 8'd2;
  localparam func_t FUNC_EVAL_4_ISOG = 8'd4;

  // one get call, then one eval call per point
  typedef enum logic [2:0] {
    IDLE,
    GET_RUN,
    COEFF_COPY,
    EVAL_RUN,
    RESULT_COPY
  } isog_state_t;

endpackage

// ==== word_ram.sv ====
`timescale 1ns/10ps

module word_ram (
  input  logic            clk,
  input  logic            wr_en,
  input  isog_pkg::addr_t wr_addr,
  input  isog_pkg::word_t din,
  input  isog_pkg::addr_t rd_addr,
  output isog_pkg::word_t dout
);
  import isog_pkg::*;

  word_t mem [MEM_DEPTH];

  // one port, a write wins over a read
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= din;
    end else begin
      dout <= mem[rd_addr];
    end
  end

endmodule

// ==== word_copier.sv ====
`timescale 1ns/10ps

module word_copier (
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  output logic            src_rd_en,
  output isog_pkg::addr_t src_rd_addr,
  output logic            wr_en,
  output isog_pkg::addr_t wr_addr,
  output logic            copy_done
);
  import isog_pkg::*;

  addr_t cnt;
  logic  rd_finished;

  // source read runs once per run window
  assign src_rd_en   = run & ~rd_finished;
  assign src_rd_addr = cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt         <= '0;
      rd_finished <= 1'b0;
    end else if (!run) begin
      cnt         <= '0;
      rd_finished <= 1'b0;
    end else if (src_rd_en) begin
      if (cnt == addr_t'(MEM_DEPTH - 1)) begin
        rd_finished <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // write trails the read by the source latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_en     <= 1'b0;
      wr_addr   <= '0;
      copy_done <= 1'b0;
    end else begin
      wr_en     <= src_rd_en;
      wr_addr   <= cnt;
      copy_done <= wr_en & (wr_addr == addr_t'(MEM_DEPTH - 1));
    end
  end

endmodule

// ==== coeff_store.sv ====
`timescale 1ns/10ps

module coeff_store (
  input  logic            clk,
  input  logic            rst,
  input  logic            eval_active,
  input  logic            wr_en,
  input  isog_pkg::addr_t wr_addr,
  input  isog_pkg::word_t t1_0,
  input  isog_pkg::word_t t1_1,
  input  isog_pkg::word_t t5_0,
  input  isog_pkg::word_t t5_1,
  input  isog_pkg::word_t t4_0,
  input  isog_pkg::word_t t4_1,
  input  logic            c_rd_en,
  input  isog_pkg::addr_t c_rd_addr,
  output isog_pkg::word_t c0_0,
  output isog_pkg::word_t c0_1,
  output isog_pkg::word_t c1_0,
  output isog_pkg::word_t c1_1,
  output isog_pkg::word_t c2_0,
  output isog_pkg::word_t c2_1
);
  import isog_pkg::*;

  word_t ram_din  [6];
  word_t ram_dout [6];
  logic  rd_gate;

  // C0 from t1, C1 from t5, C2 from t4
  assign ram_din[0] = t1_0;
  assign ram_din[1] = t1_1;
  assign ram_din[2] = t5_0;
  assign ram_din[3] = t5_1;
  assign ram_din[4] = t4_0;
  assign ram_din[5] = t4_1;

  for (genvar i = 0; i < $size(ram_din); i++) begin : g_ram
    word_ram ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .din     (ram_din[i]),
      .rd_addr (c_rd_addr),
      .dout    (ram_dout[i])
    );
  end

  // read strobe delayed to line up with the ram output
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_gate <= 1'b0;
    end else begin
      rd_gate <= c_rd_en & eval_active;
    end
  end

  // engine only sees coefficients while eval runs
  assign c0_0 = (rd_gate & eval_active) ? ram_dout[0] : '0;
  assign c0_1 = (rd_gate & eval_active) ? ram_dout[1] : '0;
  assign c1_0 = (rd_gate & eval_active) ? ram_dout[2] : '0;
  assign c1_1 = (rd_gate & eval_active) ? ram_dout[3] : '0;
  assign c2_0 = (rd_gate & eval_active) ? ram_dout[4] : '0;
  assign c2_1 = (rd_gate & eval_active) ? ram_dout[5] : '0;

endmodule

// ==== result_store.sv ====
`timescale 1ns/10ps

module result_store (
  input  logic            clk,
  input  logic            wr_en,
  input  isog_pkg::addr_t wr_addr,
  input  isog_pkg::word_t t2_0,
  input  isog_pkg::word_t t2_1,
  input  isog_pkg::word_t t3_0,
  input  isog_pkg::word_t t3_1,
  input  logic            out_rd_en,
  input  isog_pkg::addr_t out_rd_addr,
  output isog_pkg::word_t t10_0,
  output isog_pkg::word_t t10_1,
  output isog_pkg::word_t t11_0,
  output isog_pkg::word_t t11_1
);
  import isog_pkg::*;

  word_t ram_din  [4];
  word_t ram_dout [4];
  addr_t hold_addr;
  addr_t ram_rd_addr;

  assign ram_din[0] = t2_0;
  assign ram_din[1] = t2_1;
  assign ram_din[2] = t3_0;
  assign ram_din[3] = t3_1;

  // keep the last host address so the output holds between reads
  always_ff @(posedge clk) begin
    if (out_rd_en) begin
      hold_addr <= out_rd_addr;
    end
  end

  assign ram_rd_addr = out_rd_en ? out_rd_addr : hold_addr;

  for (genvar i = 0; i < $size(ram_din); i++) begin : g_ram
    word_ram ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .din     (ram_din[i]),
      .rd_addr (ram_rd_addr),
      .dout    (ram_dout[i])
    );
  end

  // t10 from t2, t11 from t3
  assign t10_0 = ram_dout[0];
  assign t10_1 = ram_dout[1];
  assign t11_0 = ram_dout[2];
  assign t11_1 = ram_dout[3];

endmodule

// ==== isog_sequencer.sv ====
`timescale 1ns/10ps

module isog_sequencer (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            last_eval,
  input  logic            xz_newly_init,
  input  logic            result_can_overwrite,
  input  logic            engine_done,
  input  logic            coef_copy_done,
  input  logic            res_copy_done,
  input  logic            x_rd_en,
  input  isog_pkg::addr_t x_rd_addr,
  output logic            busy,
  output logic            done,
  output logic            xz_can_overwrite,
  output logic            result_ready,
  output logic            engine_start,
  output isog_pkg::func_t engine_function,
  output logic            coef_copy_run,
  output logic            res_copy_run,
  output logic            eval_active
);
  import isog_pkg::*;

  isog_state_t state;
  logic        eval_pending;
  logic        x_last_rd;
  logic        x_consumed;
  logic        eval_go;

  assign coef_copy_run = (state == COEFF_COPY);
  assign res_copy_run  = (state == RESULT_COPY);
  assign eval_active   = (state == EVAL_RUN);

  // engine has fetched the final X word of this point
  assign x_last_rd = eval_active & x_rd_en & (x_rd_addr == addr_t'(MEM_DEPTH - 1));

  // new point loaded and the previous result already taken by the host
  assign eval_go = eval_pending & xz_newly_init & ~x_consumed & ~result_ready;

  // main FSM
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state           <= IDLE;
      busy            <= 1'b0;
      done            <= 1'b0;
      engine_start    <= 1'b0;
      engine_function <= FUNC_IDLE;
      eval_pending    <= 1'b0;
    end else begin
      done         <= 1'b0;
      engine_start <= 1'b0;
      unique case (state)
        IDLE: begin
          if (start && !busy) begin
            state           <= GET_RUN;
            busy            <= 1'b1;
            engine_start    <= 1'b1;
            engine_function <= FUNC_GET_4_ISOG;
          end else if (eval_go) begin
            state           <= EVAL_RUN;
            engine_start    <= 1'b1;
            engine_function <= FUNC_EVAL_4_ISOG;
            eval_pending    <= 1'b0;
          end
        end
        GET_RUN: begin
          if (engine_done) begin
            state           <= COEFF_COPY;
            engine_function <= FUNC_IDLE;
          end
        end
        COEFF_COPY: begin
          if (coef_copy_done) begin
            state        <= IDLE;
            eval_pending <= 1'b1;
          end
        end
        EVAL_RUN: begin
          if (engine_done) begin
            state           <= RESULT_COPY;
            engine_function <= FUNC_IDLE;
          end
        end
        RESULT_COPY: begin
          if (res_copy_done) begin
            state <= IDLE;
            if (last_eval) begin
              busy <= 1'b0;
              done <= 1'b1;
            end else begin
              eval_pending <= 1'b1;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // result handshake, a finished copy wins over a host release
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_ready <= 1'b0;
    end else if (res_copy_run && res_copy_done) begin
      result_ready <= 1'b1;
    end else if (result_can_overwrite) begin
      result_ready <= 1'b0;
    end
  end

  // X/Z handshake
  // x_consumed masks the stale init level until the host drops it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      xz_can_overwrite <= 1'b1;
      x_consumed       <= 1'b0;
    end else begin
      if (x_last_rd) begin
        x_consumed <= 1'b1;
      end else if (!xz_newly_init) begin
        x_consumed <= 1'b0;
      end

      if (x_last_rd) begin
        xz_can_overwrite <= 1'b1;
      end else if (xz_newly_init && !x_consumed) begin
        xz_can_overwrite <= 1'b0;
      end
    end
  end

endmodule

// ==== isog_top.sv ====
`timescale 1ns/10ps

module isog_top (
  input  logic            clk,
  input  logic            rst,
  // host control
  input  logic            start,
  output logic            busy,
  output logic            done,
  output logic            xz_can_overwrite,
  input  logic            xz_newly_init,
  input  logic            last_eval,
  output logic            result_ready,
  input  logic            result_can_overwrite,
  // host result reads
  input  logic            out_rd_en,
  input  isog_pkg::addr_t out_rd_addr,
  output isog_pkg::word_t t10_0,
  output isog_pkg::word_t t10_1,
  output isog_pkg::word_t t11_0,
  output isog_pkg::word_t t11_1,
  // engine control
  output logic            engine_start,
  output isog_pkg::func_t engine_function,
  input  logic            engine_done,
  input  logic            x_rd_en,
  input  isog_pkg::addr_t x_rd_addr,
  // engine registers read by the coefficient copy
  output logic            coef_src_rd_en,
  output isog_pkg::addr_t coef_src_rd_addr,
  input  isog_pkg::word_t t1_0,
  input  isog_pkg::word_t t1_1,
  input  isog_pkg::word_t t5_0,
  input  isog_pkg::word_t t5_1,
  input  isog_pkg::word_t t4_0,
  input  isog_pkg::word_t t4_1,
  // engine registers read by the result copy
  output logic            res_src_rd_en,
  output isog_pkg::addr_t res_src_rd_addr,
  input  isog_pkg::word_t t2_0,
  input  isog_pkg::word_t t2_1,
  input  isog_pkg::word_t t3_0,
  input  isog_pkg::word_t t3_1,
  // coefficient reads by the engine
  input  logic            c_rd_en,
  input  isog_pkg::addr_t c_rd_addr,
  output isog_pkg::word_t c0_0,
  output isog_pkg::word_t c0_1,
  output isog_pkg::word_t c1_0,
  output isog_pkg::word_t c1_1,
  output isog_pkg::word_t c2_0,
  output isog_pkg::word_t c2_1
);
  import isog_pkg::*;

  logic  coef_copy_run;
  logic  coef_copy_done;
  logic  coef_wr_en;
  addr_t coef_wr_addr;
  logic  res_copy_run;
  logic  res_copy_done;
  logic  res_wr_en;
  addr_t res_wr_addr;
  logic  eval_active;

  isog_sequencer seq (
    .clk                  (clk),
    .rst                  (rst),
    .start                (start),
    .last_eval            (last_eval),
    .xz_newly_init        (xz_newly_init),
    .result_can_overwrite (result_can_overwrite),
    .engine_done          (engine_done),
    .coef_copy_done       (coef_copy_done),
    .res_copy_done        (res_copy_done),
    .x_rd_en              (x_rd_en),
    .x_rd_addr            (x_rd_addr),
    .busy                 (busy),
    .done                 (done),
    .xz_can_overwrite     (xz_can_overwrite),
    .result_ready         (result_ready),
    .engine_start         (engine_start),
    .engine_function      (engine_function),
    .coef_copy_run        (coef_copy_run),
    .res_copy_run         (res_copy_run),
    .eval_active          (eval_active)
  );

  // t1/t5/t4 into the coefficient store after get
  word_copier coef_copier (
    .clk         (clk),
    .rst         (rst),
    .run         (coef_copy_run),
    .src_rd_en   (coef_src_rd_en),
    .src_rd_addr (coef_src_rd_addr),
    .wr_en       (coef_wr_en),
    .wr_addr     (coef_wr_addr),
    .copy_done   (coef_copy_done)
  );

  // t2/t3 into the result store after each eval
  word_copier res_copier (
    .clk         (clk),
    .rst         (rst),
    .run         (res_copy_run),
    .src_rd_en   (res_src_rd_en),
    .src_rd_addr (res_src_rd_addr),
    .wr_en       (res_wr_en),
    .wr_addr     (res_wr_addr),
    .copy_done   (res_copy_done)
  );

  coeff_store coef_store (
    .clk         (clk),
    .rst         (rst),
    .eval_active (eval_active),
    .wr_en       (coef_wr_en),
    .wr_addr     (coef_wr_addr),
    .t1_0        (t1_0),
    .t1_1        (t1_1),
    .t5_0        (t5_0),
    .t5_1        (t5_1),
    .t4_0        (t4_0),
    .t4_1        (t4_1),
    .c_rd_en     (c_rd_en),
    .c_rd_addr   (c_rd_addr),
    .c0_0        (c0_0),
    .c0_1        (c0_1),
    .c1_0        (c1_0),
    .c1_1        (c1_1),
    .c2_0        (c2_0),
    .c2_1        (c2_1)
  );

  result_store res_store (
    .clk         (clk),
    .wr_en       (res_wr_en),
    .wr_addr     (res_wr_addr),
    .t2_0        (t2_0),
    .t2_1        (t2_1),
    .t3_0        (t3_0),
    .t3_1        (t3_1),
    .out_rd_en   (out_rd_en),
    .out_rd_addr (out_rd_addr),
    .t10_0       (t10_0),
    .t10_1       (t10_1),
    .t11_0       (t11_0),
    .t11_1       (t11_1)
  );

endmodule

// ==== isog_assertions.sv ====
`timescale 1ns/10ps

module isog_assertions (
  input logic            clk,
  input logic            rst,
  input logic            busy,
  input logic            done,
  input logic            engine_start,
  input logic            result_ready,
  input isog_pkg::func_t engine_function
);
  import isog_pkg::*;

  // engine start is a single-cycle pulse
  start_pulse: assert property (@(posedge clk) disable iff (rst)
    engine_start |=> !engine_start)
    else $error("engine_start held longer than one cycle");

  done_with_busy_fall: assert property (@(posedge clk) disable iff (rst)
    done |-> $fell(busy))
    else $error("done pulsed without busy falling");

  // a result only appears once the eval call has ended
  no_result_in_eval: assert property (@(posedge clk) disable iff (rst)
    $rose(result_ready) |-> (engine_function != FUNC_EVAL_4_ISOG))
    else $error("result_ready rose while eval was running");

endmodule

bind isog_top isog_assertions i_isog_assertions (
  .clk             (clk),
  .rst             (rst),
  .busy            (busy),
  .done            (done),
  .engine_start    (engine_start),
  .result_ready    (result_ready),
  .engine_function (engine_function)
);

// ==== tb_isog_top.sv ====
`timescale 1ns/10ps

module tb_isog_top;
  import isog_pkg::*;

  localparam int CLK_PERIOD        = 40;
  localparam int RST_CYCLES        = 5;
  localparam int NUM_ROWS          = 4;
  localparam int GET_LATENCY       = 6;
  localparam int WAIT_LIMIT        = 500;
  localparam int ENGINE_IDLE_LIMIT = 2000;
  localparam int W_XZ              = 0;
  localparam int W_RESULT          = 1;

  logic  clk;
  logic  rst;
  logic  start, busy, done;
  logic  xz_can_overwrite, xz_newly_init, last_eval;
  logic  result_ready, result_can_overwrite;
  logic  out_rd_en;
  addr_t out_rd_addr;
  word_t t10_0, t10_1, t11_0, t11_1;
  logic  engine_start, engine_done;
  func_t engine_function;
  logic  x_rd_en;
  addr_t x_rd_addr;
  logic  coef_src_rd_en, res_src_rd_en;
  addr_t coef_src_rd_addr, res_src_rd_addr;
  word_t t1_0, t1_1, t5_0, t5_1, t4_0, t4_1;
  word_t t2_0, t2_1, t3_0, t3_1;
  logic  c_rd_en;
  addr_t c_rd_addr;
  word_t c0_0, c0_1, c1_0, c1_1, c2_0, c2_1;

  // stimulus table, one row per eval call
  // latency is idle engine cycles after the X reads
  // release is host cycles between reading a result and freeing it
  int row_latency [NUM_ROWS] = '{3, 11, 0, 6};
  bit row_last    [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};
  int row_release [NUM_ROWS] = '{0, 9, 2, 5};

  // expected function code at each engine start, get first
  func_t start_func [NUM_ROWS+1] = '{FUNC_GET_4_ISOG, FUNC_EVAL_4_ISOG, FUNC_EVAL_4_ISOG,
                                     FUNC_EVAL_4_ISOG, FUNC_EVAL_4_ISOG};

  // engine registers: t1, t5, t4 and t2, t3, two halves each
  word_t  coef_regs [6][MEM_DEPTH];
  word_t  res_regs  [4][MEM_DEPTH];
  integer seed        = 76;
  int     fail_count  = 0;
  int     start_count = 0;
  int     done_count  = 0;

  isog_top i_isog_top (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // all DUT outputs are registered, so they are stable here
  task automatic tick;
    @(posedge clk);
    #2;
  endtask

  task automatic report_failure(input string what);
    fail_count++;
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s: expected %08h, actual %08h",
                               name, expected, actual));
    end
  endtask

  function automatic logic watched(input int sel);
    if (sel == W_XZ) begin
      return xz_can_overwrite;
    end
    return result_ready;
  endfunction

  task automatic wait_until(input string what, input int sel, input logic level);
    int cycles;
    cycles = 0;
    while (watched(sel) !== level) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure($sformatf("timeout while waiting for %s", what));
      end
      tick;
    end
  endtask

  task automatic run_get(input int latency);
    repeat (latency) tick;
    engine_done = 1'b1;
    tick;
    engine_done = 1'b0;
  endtask

  task automatic run_eval(input int row, input int latency);
    for (int r = 0; r < 4; r++) begin
      for (int a = 0; a < MEM_DEPTH; a++) begin
        res_regs[r][a] = $random(seed);
      end
    end
    // coefficient data comes one cycle after its address
    for (int a = 0; a < MEM_DEPTH; a++) begin
      c_rd_en   = 1'b1;
      c_rd_addr = addr_t'(a);
      tick;
      check_value($sformatf("eval %0d c0_0 addr %0d", row, a), coef_regs[0][a], c0_0);
      check_value($sformatf("eval %0d c0_1 addr %0d", row, a), coef_regs[1][a], c0_1);
      check_value($sformatf("eval %0d c1_0 addr %0d", row, a), coef_regs[2][a], c1_0);
      check_value($sformatf("eval %0d c1_1 addr %0d", row, a), coef_regs[3][a], c1_1);
      check_value($sformatf("eval %0d c2_0 addr %0d", row, a), coef_regs[4][a], c2_0);
      check_value($sformatf("eval %0d c2_1 addr %0d", row, a), coef_regs[5][a], c2_1);
    end
    c_rd_en = 1'b0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      check_value($sformatf("eval %0d xz_can_overwrite before X read %0d", row, a),
                  0, 32'(xz_can_overwrite));
      x_rd_en   = 1'b1;
      x_rd_addr = addr_t'(a);
      tick;
    end
    x_rd_en = 1'b0;
    check_value($sformatf("eval %0d xz_can_overwrite after last X read", row),
                1, 32'(xz_can_overwrite));
    repeat (latency) tick;
    // a read on the last eval cycle returns data after eval has ended
    c_rd_en     = 1'b1;
    c_rd_addr   = addr_t'(row);
    engine_done = 1'b1;
    tick;
    engine_done = 1'b0;
    c_rd_en     = 1'b0;
    check_value($sformatf("eval %0d c0_0 gated after done", row), 0, c0_0);
    check_value($sformatf("eval %0d c2_1 gated after done", row), 0, c2_1);
  endtask

  task automatic read_results(input int row);
    for (int a = 0; a < MEM_DEPTH; a++) begin
      out_rd_en   = 1'b1;
      out_rd_addr = addr_t'(a);
      tick;
      check_value($sformatf("row %0d t10_0 addr %0d", row, a), res_regs[0][a], t10_0);
      check_value($sformatf("row %0d t10_1 addr %0d", row, a), res_regs[1][a], t10_1);
      check_value($sformatf("row %0d t11_0 addr %0d", row, a), res_regs[2][a], t11_0);
      check_value($sformatf("row %0d t11_1 addr %0d", row, a), res_regs[3][a], t11_1);
    end
    out_rd_en = 1'b0;
  endtask

  // engine sequencing: answers each engine_start
  initial begin : engine_model
    int idle;
    int idx;
    int eval_idx;
    engine_done = 1'b0;
    x_rd_en     = 1'b0;
    x_rd_addr   = '0;
    c_rd_en     = 1'b0;
    c_rd_addr   = '0;
    eval_idx    = 0;
    forever begin
      idle = 0;
      tick;
      while (engine_start !== 1'b1) begin
        idle++;
        if (idle > ENGINE_IDLE_LIMIT) begin
          report_failure("engine model waited too long for engine_start");
        end
        tick;
      end
      if (done_count != 0) begin
        report_failure("engine_start seen after done");
      end
      if (start_count > NUM_ROWS) begin
        report_failure("more engine starts than rows in the table");
      end
      idx = start_count;
      start_count++;
      check_value($sformatf("function at engine start %0d", idx),
                  32'(start_func[idx]), 32'(engine_function));
      if (start_func[idx] == FUNC_EVAL_4_ISOG) begin
        check_value($sformatf("result_ready at eval start %0d", eval_idx),
                    0, 32'(result_ready));
        run_eval(eval_idx, row_latency[eval_idx]);
        eval_idx++;
      end else begin
        run_get(GET_LATENCY);
      end
    end
  end

  // engine register file, read data one cycle behind the address
  initial begin : register_reads
    addr_t coef_addr;
    addr_t res_addr;
    coef_addr = '0;
    res_addr  = '0;
    {t1_0, t1_1, t5_0, t5_1, t4_0, t4_1} = '0;
    {t2_0, t2_1, t3_0, t3_1} = '0;
    forever begin
      tick;
      t1_0 = coef_regs[0][coef_addr];
      t1_1 = coef_regs[1][coef_addr];
      t5_0 = coef_regs[2][coef_addr];
      t5_1 = coef_regs[3][coef_addr];
      t4_0 = coef_regs[4][coef_addr];
      t4_1 = coef_regs[5][coef_addr];
      t2_0 = res_regs[0][res_addr];
      t2_1 = res_regs[1][res_addr];
      t3_0 = res_regs[2][res_addr];
      t3_1 = res_regs[3][res_addr];
      if (coef_src_rd_en) begin
        coef_addr = coef_src_rd_addr;
      end
      if (res_src_rd_en) begin
        res_addr = res_src_rd_addr;
      end
    end
  end

  initial begin : done_monitor
    forever begin
      tick;
      if (done === 1'b1) begin
        done_count++;
      end
    end
  end

  initial begin : host_sequence
    rst                  = 1'b1;
    start                = 1'b0;
    xz_newly_init        = 1'b0;
    last_eval            = 1'b0;
    result_can_overwrite = 1'b0;
    out_rd_en            = 1'b0;
    out_rd_addr          = '0;
    for (int r = 0; r < 6; r++) begin
      for (int a = 0; a < MEM_DEPTH; a++) begin
        coef_regs[r][a] = $random(seed);
      end
    end
    repeat (RST_CYCLES) tick;
    rst = 1'b0;
    tick;
    check_value("busy after reset", 0, 32'(busy));
    check_value("done after reset", 0, 32'(done));
    check_value("result_ready after reset", 0, 32'(result_ready));
    check_value("engine_start after reset", 0, 32'(engine_start));
    check_value("engine_function after reset", 32'(FUNC_IDLE), 32'(engine_function));
    check_value("xz_can_overwrite after reset", 1, 32'(xz_can_overwrite));

    // first point loaded before the get call
    xz_newly_init = 1'b1;
    wait_until("xz_can_overwrite to fall for point 0", W_XZ, 1'b0);
    start = 1'b1;
    tick;
    start = 1'b0;
    check_value("busy after start", 1, 32'(busy));

    for (int i = 0; i < NUM_ROWS; i++) begin
      last_eval = row_last[i];
      wait_until($sformatf("X input of point %0d consumed", i), W_XZ, 1'b1);
      xz_newly_init = 1'b0;
      wait_until($sformatf("result_ready of point %0d", i), W_RESULT, 1'b1);
      if (row_last[i]) begin
        check_value("done with last result", 1, 32'(done));
        check_value("busy with last result", 0, 32'(busy));
      end else begin
        check_value($sformatf("busy with result %0d", i), 1, 32'(busy));
      end
      read_results(i);
      if (!row_last[i]) begin
        // next point is ready while this result is still held
        xz_newly_init = 1'b1;
        wait_until($sformatf("xz_can_overwrite to fall for point %0d", i + 1), W_XZ, 1'b0);
        // a start pulse while busy must not begin another get
        start = 1'b1;
        tick;
        start = 1'b0;
        check_value($sformatf("engine_start on start while busy, row %0d", i),
                    0, 32'(engine_start));
      end
      repeat (row_release[i]) tick;
      result_can_overwrite = 1'b1;
      wait_until($sformatf("result_ready release of point %0d", i), W_RESULT, 1'b0);
      result_can_overwrite = 1'b0;
    end

    // quiet period, no engine activity may follow
    repeat (20) tick;
    check_value("done pulse count", 1, done_count);
    check_value("busy at end", 0, 32'(busy));
    check_value("engine start count", NUM_ROWS + 1, start_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure("checks failed before the end of the run");
    end
  end

endmodule

// ==== build.f ====
isog_pkg.sv
word_ram.sv
word_copier.sv
coeff_store.sv
result_store.sv
isog_sequencer.sv
isog_top.sv
isog_assertions.sv
tb_isog_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the isog_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_isog_top \
  -f build.f \
  -o tb_isog_top

./obj_dir/tb_isog_top
